//--- sources.f
source/exe_pkg.sv
source/hilo_if.sv
source/exe_alu.sv
source/serial_divider.sv
source/hilo_unit.sv
source/mem_access.sv
source/exe_stage.sv
verification/exe_stage_assert.sv
verification/exe_stage_tb.sv

//--- Makefile
TOP = exe_stage_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

//--- verification/exe_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exe_stage_tb
    import exe_pkg::*;
();

    typedef struct packed {
        exe_op_t   op;
        word_t     rs;
        word_t     rt;
        imm_t      imm;
        word_t     res;
        exc_code_t exc;
        logic      wr;
        strobe_t   strb;
        word_t     wdata;
    } row_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    exe_op_t    in_op;
    word_t      in_rs;
    word_t      in_rt;
    imm_t       in_imm;
    reg_addr_t  in_dest;
    logic       in_ready;
    logic       out_valid;
    word_t      out_result;
    reg_addr_t  out_dest;
    logic       out_write;
    exc_code_t  out_exc;
    logic       out_load;
    logic [1:0] out_offset;
    logic       out_ready;
    logic       mem_req;
    logic       mem_write;
    word_t      mem_addr;
    strobe_t    mem_wstrb;
    word_t      mem_wdata;
    logic       mem_addr_ok;

    row_t       rows[$];
    row_t       seen;
    word_t      lfsr = 32'h5e81_cc77;
    logic [1:0] bus_wait = 2'd0;
    logic       table_ready = 1'b0;
    logic       row_bad = 1'b0;
    int         out_idx = 0;
    int         errors = 0;
    int         checks = 0;
    int         accepted = 0;
    int         expected_requests = 0;

    exe_stage i_dut (.*);

    bind exe_stage exe_stage_assert i_assert (.*);

    always #50 clk = ~clk;

    // galois form, one bit out per step
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic is_store_op(exe_op_t op);
        return op == op_sb || op == op_sh || op == op_sw;
    endfunction

    function automatic logic is_load_op(exe_op_t op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    endfunction

    function automatic logic writes_hilo(exe_op_t op);
        return op inside {op_mult, op_multu, op_div, op_divu, op_mthi, op_mtlo};
    endfunction

    function automatic word_t expected_alu(exe_op_t op, word_t rs, word_t rt, imm_t imm);
        word_t      se;
        word_t      ze;
        logic [4:0] sa;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        sa = imm[10:6];
        case (op)
            op_addu:  return rs + rt;
            op_subu:  return rs - rt;
            op_and:   return rs & rt;
            op_or:    return rs | rt;
            op_xor:   return rs ^ rt;
            op_nor:   return ~(rs | rt);
            op_slt:   return {31'b0, $signed(rs) < $signed(rt)};
            op_sltu:  return {31'b0, rs < rt};
            op_sll:   return rt << sa;
            op_srl:   return rt >> sa;
            op_sra:   return word_t'($signed(rt) >>> sa);
            op_addiu: return rs + se;
            op_andi:  return rs & ze;
            op_ori:   return rs | ze;
            op_xori:  return rs ^ ze;
            op_slti:  return {31'b0, $signed(rs) < $signed(se)};
            op_sltiu: return {31'b0, rs < se};
            default:  return {imm, 16'h0000};
        endcase
    endfunction

    task automatic add_row(exe_op_t op, word_t rs, word_t rt, imm_t imm, word_t res,
                           exc_code_t exc, logic wr, strobe_t strb, word_t wdata);
        rows.push_back('{op, rs, rt, imm, res, exc, wr, strb, wdata});
        if ((is_load_op(op) || is_store_op(op)) && exc == exc_none) begin
            expected_requests++;
        end
    endtask

    task automatic random_row(exe_op_t op);
        word_t rs;
        word_t rt;
        imm_t  imm;
        rs  = rand_bits(32);
        rt  = rand_bits(32);
        imm = imm_t'(rand_bits(16));
        add_row(op, rs, rt, imm, expected_alu(op, rs, rt, imm), exc_none, 1'b1, 4'h0, 32'h0);
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_bad = 1'b1;
            $display("error at %0t: row %0d %s is %h, expected %h", $time, out_idx, what, got, exp);
        end
    endtask

    task automatic check_exc(exc_code_t got, exc_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_bad = 1'b1;
            $display("error at %0t: row %0d exception is %s, expected %s",
                     $time, out_idx, got.name(), exp.name());
        end
    endtask

    task automatic check_strobe(strobe_t got, strobe_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_bad = 1'b1;
            $display("error at %0t: row %0d byte strobe is %b, expected %b",
                     $time, out_idx, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_bad = 1'b1;
            $display("error at %0t: row %0d %s is %b, expected %b", $time, out_idx, what, got, exp);
        end
    endtask

    task automatic build_table();
        exe_op_t rnd_ops[18] = '{op_addu, op_subu, op_and, op_or, op_xor, op_nor, op_slt,
                                 op_sltu, op_sll, op_srl, op_sra, op_addiu, op_andi, op_ori,
                                 op_xori, op_slti, op_sltiu, op_lui};
        add_row(op_add,   32'h5, 32'h7, 16'h0, 32'hc, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_sub,   32'h5, 32'h7, 16'h0, 32'hffff_fffe, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_and,   32'hf0f0_1234, 32'h0ff0_ffff, 16'h0, 32'h00f0_1234, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_or,    32'hf0f0_1234, 32'h0ff0_ffff, 16'h0, 32'hfff0_ffff, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_nor,   32'h0, 32'h0, 16'h0, 32'hffff_ffff, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_slt,   32'hffff_ffff, 32'h1, 16'h0, 32'h1, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_sltu,  32'hffff_ffff, 32'h1, 16'h0, 32'h0, exc_none, 1'b1, 4'h0, 32'h0);
        // shift amount sits in imm[10:6]
        add_row(op_sll,   32'h0, 32'h8000_0001, 16'h0100, 32'h10, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_srl,   32'h0, 32'h8000_0000, 16'h07c0, 32'h1, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_sra,   32'h0, 32'h8000_0000, 16'h0100, 32'hf800_0000, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_andi,  32'hffff_ffff, 32'h0, 16'h8001, 32'h8001, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_ori,   32'h1234_0000, 32'h0, 16'h8000, 32'h1234_8000, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_xori,  32'hffff_ffff, 32'h0, 16'hffff, 32'hffff_0000, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_addi,  32'ha, 32'h0, 16'hffff, 32'h9, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_slti,  32'h0, 32'h0, 16'hffff, 32'h0, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_sltiu, 32'h0, 32'h0, 16'hffff, 32'h1, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_lui,   32'h0, 32'h0, 16'hbeef, 32'hbeef_0000, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_add,   32'h7fff_ffff, 32'h1, 16'h0, 32'h0, exc_overflow, 1'b0, 4'h0, 32'h0);
        add_row(op_addu,  32'h7fff_ffff, 32'h1, 16'h0, 32'h8000_0000, exc_none, 1'b1,
                4'h0, 32'h0);
        add_row(op_addi,  32'h7fff_ffff, 32'h0, 16'h1, 32'h0, exc_overflow, 1'b0, 4'h0, 32'h0);
        add_row(op_sub,   32'h8000_0000, 32'h1, 16'h0, 32'h0, exc_overflow, 1'b0, 4'h0, 32'h0);
        // -2 times 3
        add_row(op_mult,  32'hffff_fffe, 32'h3, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'hffff_ffff, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'hffff_fffa, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_multu, 32'hffff_ffff, 32'hffff_ffff, 16'h0, 32'h0, exc_none, 1'b0,
                4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'hffff_fffe, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'h1, exc_none, 1'b1, 4'h0, 32'h0);
        // -7 / 2 gives -3 rem -1
        add_row(op_div,   32'hffff_fff9, 32'h2, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'hffff_ffff, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'hffff_fffd, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_divu,  32'h64, 32'h7, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'h2, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'he, exc_none, 1'b1, 4'h0, 32'h0);
        // zero divisor, all-ones magnitude then sign fix
        add_row(op_div,   32'hffff_fffb, 32'h0, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'hffff_fffb, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'h1, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_divu,  32'h1234, 32'h0, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'h1234, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'hffff_ffff, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mthi,  32'hcafe_f00d, 32'h0, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mtlo,  32'h1357_9bdf, 32'h0, 16'h0, 32'h0, exc_none, 1'b0, 4'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0, 16'h0, 32'hcafe_f00d, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0, 16'h0, 32'h1357_9bdf, exc_none, 1'b1, 4'h0, 32'h0);
        // stores, result column holds the bus address
        add_row(op_sb, 32'h1000_0000, 32'h1122_33a5, 16'h0, 32'h1000_0000, exc_none, 1'b0,
                4'h1, 32'ha5a5_a5a5);
        add_row(op_sb, 32'h1000_0000, 32'h1122_33a5, 16'h1, 32'h1000_0001, exc_none, 1'b0,
                4'h2, 32'ha5a5_a5a5);
        add_row(op_sb, 32'h1000_0000, 32'h1122_33a5, 16'h2, 32'h1000_0002, exc_none, 1'b0,
                4'h4, 32'ha5a5_a5a5);
        add_row(op_sb, 32'h1000_0000, 32'h1122_33a5, 16'h3, 32'h1000_0003, exc_none, 1'b0,
                4'h8, 32'ha5a5_a5a5);
        add_row(op_sh, 32'h1000_0000, 32'h1122_beef, 16'h0, 32'h1000_0000, exc_none, 1'b0,
                4'h3, 32'hbeef_beef);
        add_row(op_sh, 32'h1000_0000, 32'h1122_beef, 16'h2, 32'h1000_0002, exc_none, 1'b0,
                4'hc, 32'hbeef_beef);
        add_row(op_sh, 32'h1000_0000, 32'h1122_beef, 16'h1, 32'h0, exc_ades, 1'b0, 4'h0, 32'h0);
        add_row(op_sw, 32'h1000_0010, 32'hdead_beef, 16'hfffc, 32'h1000_000c, exc_none, 1'b0,
                4'hf, 32'hdead_beef);
        add_row(op_sw, 32'h1000_0000, 32'hdead_beef, 16'h2, 32'h0, exc_ades, 1'b0, 4'h0, 32'h0);
        add_row(op_lw,  32'h1000_0000, 32'h0, 16'h6, 32'h0, exc_adel, 1'b0, 4'h0, 32'h0);
        add_row(op_lh,  32'h1000_0000, 32'h0, 16'h3, 32'h0, exc_adel, 1'b0, 4'h0, 32'h0);
        add_row(op_lb,  32'h1000_0000, 32'h0, 16'h3, 32'h1000_0003, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_lhu, 32'h1000_0000, 32'h0, 16'h2, 32'h1000_0002, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_lw,  32'h1000_0000, 32'h0, 16'h8, 32'h1000_0008, exc_none, 1'b1, 4'h0, 32'h0);
        add_row(op_lbu, 32'h1000_0002, 32'h0, 16'hffff, 32'h1000_0001, exc_none, 1'b1,
                4'h0, 32'h0);
        for (int i = 0; i < 18; i++) begin
            random_row(rnd_ops[i]);
        end
    endtask

    // bus model and back-pressure, new values each falling edge
    always @(negedge clk) begin
        out_ready = (rand_bits(2) != 32'd0);
        if (mem_addr_ok) begin
            bus_wait = 2'(rand_bits(2));
        end
        if (mem_req && bus_wait == 2'd0) begin
            mem_addr_ok = 1'b1;
        end else begin
            mem_addr_ok = 1'b0;
            if (mem_req) begin
                bus_wait = bus_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && mem_req && mem_addr_ok) begin
            accepted++;
            if (out_idx < rows.size()) begin
                seen = rows[out_idx];
                check_word("mem_addr", mem_addr, seen.res);
                check_strobe(mem_wstrb, seen.strb);
                check_flag("mem_write", mem_write, is_store_op(seen.op));
                if (is_store_op(seen.op)) begin
                    check_word("mem_wdata", mem_wdata, seen.wdata);
                end
            end
        end
        if (!reset && out_valid && out_ready) begin
            if (out_idx >= rows.size()) begin
                errors++;
                $display("the stage produced an output after every row had already left");
            end else begin
                seen = rows[out_idx];
                check_exc(out_exc, seen.exc);
                check_flag("out_write", out_write, seen.wr);
                check_flag("out_load", out_load, is_load_op(seen.op));
                check_word("out_dest", {27'b0, out_dest}, word_t'(out_idx % 32));
                if (seen.exc == exc_none && !writes_hilo(seen.op)) begin
                    check_word("out_result", out_result, seen.res);
                end
                if (seen.exc == exc_none && is_load_op(seen.op)) begin
                    check_word("out_offset", {30'b0, out_offset}, {30'b0, seen.res[1:0]});
                end
                $display("row %0d %s %s", out_idx, seen.op.name(), row_bad ? "mismatch" : "ok");
                row_bad = 1'b0;
                out_idx++;
            end
        end
    end

    initial begin
        wait (table_ready);
        #(rows.size() * 60 * 100);
        $display("timeout: only %0d of %0d rows left the stage", out_idx, rows.size());
        $display("Something failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        // decode offers an instruction while reset holds the stage empty
        in_valid    = 1'b1;
        in_op       = op_add;
        in_rs       = '0;
        in_rt       = '0;
        in_imm      = '0;
        in_dest     = '0;
        out_ready   = 1'b0;
        mem_addr_ok = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        in_valid = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_op    = rows[i].op;
            in_rs    = rows[i].rs;
            in_rt    = rows[i].rt;
            in_imm   = rows[i].imm;
            in_dest  = reg_addr_t'(i % 32);
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (out_idx == rows.size());
        repeat (4) @(negedge clk);
        if (accepted != expected_requests) begin
            errors++;
            $display("error at %0t: %0d bus requests accepted, expected %0d",
                     $time, accepted, expected_requests);
        end
        $display("%0d rows, %0d checks, %0d errors, %0d bus requests",
                 rows.size(), checks, errors, accepted);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/exe_stage_assert.sv
`timescale 1ns/1ns
`default_nettype none

module exe_stage_assert
    import exe_pkg::*;
(
    input wire logic    clk,
    input wire logic    reset,
    input wire logic    mem_req,
    input wire logic    mem_addr_ok,
    input wire logic    mem_write,
    input wire word_t   mem_addr,
    input wire strobe_t mem_wstrb,
    input wire logic    out_valid
);

    // a pending request keeps its address until taken
    req_holds: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr))
        else $error("mem_req dropped or mem_addr moved before mem_addr_ok");

    loads_no_strobe: assert property (@(posedge clk) disable iff (reset)
        !mem_write |-> mem_wstrb == 4'h0)
        else $error("mem_wstrb is set on a read request");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid is high while reset is applied");

endmodule

`default_nettype wire

//--- source/exe_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exe_stage
    import exe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // decode side
    input  logic       in_valid,
    input  exe_op_t    in_op,
    input  word_t      in_rs,
    input  word_t      in_rt,
    input  imm_t       in_imm,
    input  reg_addr_t  in_dest,
    output logic       in_ready,
    // memory stage side
    output logic       out_valid,
    output word_t      out_result,
    output reg_addr_t  out_dest,
    output logic       out_write,
    output exc_code_t  out_exc,
    output logic       out_load,
    output logic [1:0] out_offset,
    input  logic       out_ready,
    // data bus
    output logic       mem_req,
    output logic       mem_write,
    output word_t      mem_addr,
    output strobe_t    mem_wstrb,
    output word_t      mem_wdata,
    input  logic       mem_addr_ok
);

    logic      valid_r;
    exe_op_t   op_r;
    word_t     rs_r;
    word_t     rt_r;
    imm_t      imm_r;
    reg_addr_t dest_r;

    word_t     alu_result;
    logic      alu_overflow;
    logic      misaligned;
    logic      mem_accepted;
    logic      mem_active;
    logic      hold_div;
    logic      div_done_r;
    logic      ready_go;
    logic      leave;
    exc_code_t exc;

    hilo_if hl ();

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_ready) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_r   <= in_op;
            rs_r   <= in_rs;
            rt_r   <= in_rt;
            imm_r  <= in_imm;
            dest_r <= in_dest;
        end
    end

    exe_alu i_alu (
        .op       (op_r),
        .rs       (rs_r),
        .rt       (rt_r),
        .imm      (imm_r),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // overflow first, then adel, then ades
    always_comb begin
        if (alu_overflow) begin
            exc = exc_overflow;
        end else if (misaligned && !is_store(op_r)) begin
            exc = exc_adel;
        end else if (misaligned) begin
            exc = exc_ades;
        end else begin
            exc = exc_none;
        end
    end

    assign mem_active = valid_r && is_mem_op(op_r) && (exc == exc_none);
    assign hold_div   = valid_r && (op_r inside {op_div, op_divu});

    // done is a single pulse, keep it while the result waits
    always_ff @(posedge clk) begin
        if (reset || leave) begin
            div_done_r <= 1'b0;
        end else if (hl.done) begin
            div_done_r <= 1'b1;
        end
    end

    always_comb begin
        if (hold_div) begin
            ready_go = hl.done || div_done_r;
        end else if (mem_active) begin
            ready_go = mem_accepted;
        end else begin
            ready_go = 1'b1;
        end
    end

    assign out_valid = valid_r && ready_go;
    assign leave     = out_valid && out_ready;
    assign in_ready  = !valid_r || leave;

    assign hl.op     = op_r;
    assign hl.rs     = rs_r;
    assign hl.rt     = rt_r;
    assign hl.start  = hold_div && !hl.busy && !hl.done && !div_done_r;
    assign hl.commit = leave && is_hilo_op(op_r) && !(op_r inside {op_div, op_divu});

    hilo_unit i_hilo (
        .clk   (clk),
        .reset (reset),
        .hl    (hl.unit)
    );

    mem_access i_mem (
        .clk         (clk),
        .reset       (reset),
        .active      (mem_active),
        .leave       (leave),
        .op          (op_r),
        .addr        (alu_result),
        .rt          (rt_r),
        .misaligned  (misaligned),
        .accepted    (mem_accepted),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wstrb   (mem_wstrb),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok)
    );

    always_comb begin
        case (op_r)
            op_mfhi: out_result = hl.hi;
            op_mflo: out_result = hl.lo;
            default: out_result = alu_result;
        endcase
    end

    assign out_dest   = dest_r;
    assign out_exc    = exc;
    assign out_write  = !is_store(op_r) && !is_hilo_op(op_r) && (exc == exc_none);
    assign out_load   = is_mem_op(op_r) && !is_store(op_r);
    assign out_offset = alu_result[1:0];

endmodule

`default_nettype wire

//--- source/mem_access.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access
    import exe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    active,
    input  logic    leave,
    input  exe_op_t op,
    input  word_t   addr,
    input  word_t   rt,
    output logic    misaligned,
    output logic    accepted,
    output logic    mem_req,
    output logic    mem_write,
    output word_t   mem_addr,
    output strobe_t mem_wstrb,
    output word_t   mem_wdata,
    input  logic    mem_addr_ok
);

    acc_size_t size;
    logic      sent;

    assign size = access_size(op);

    always_comb begin
        misaligned = 1'b0;
        if (is_mem_op(op)) begin
            case (size)
                acc_half: misaligned = addr[0];
                acc_word: misaligned = (addr[1:0] != 2'b00);
                default:  misaligned = 1'b0;
            endcase
        end
    end

    // byte lanes for stores only
    always_comb begin
        mem_wstrb = '0;
        if (is_store(op)) begin
            case (size)
                acc_byte: mem_wstrb = strobe_t'(4'b0001 << addr[1:0]);
                acc_half: mem_wstrb = addr[1] ? 4'b1100 : 4'b0011;
                default:  mem_wstrb = 4'b1111;
            endcase
        end
    end

    always_comb begin
        case (size)
            acc_byte: mem_wdata = {4{rt[7:0]}};
            acc_half: mem_wdata = {2{rt[15:0]}};
            default:  mem_wdata = rt;
        endcase
    end

    // one request per instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            sent <= 1'b0;
        end else if (leave) begin
            sent <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            sent <= 1'b1;
        end
    end

    assign mem_req   = active && !sent;
    assign mem_write = is_store(op);
    assign mem_addr  = addr;
    assign accepted  = (mem_req && mem_addr_ok) || sent;

endmodule

`default_nettype wire

//--- source/hilo_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hilo_unit
    import exe_pkg::*;
(
    input logic   clk,
    input logic   reset,
    hilo_if.unit  hl
);

    word_t       hi_r;
    word_t       lo_r;
    word_t       quotient;
    word_t       remainder;
    logic        div_busy;
    logic        div_done;
    logic [63:0] prod_s;
    logic [63:0] prod_u;

    serial_divider i_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (hl.start),
        .is_signed (hl.op == op_div),
        .dividend  (hl.rs),
        .divisor   (hl.rt),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (div_busy),
        .done      (div_done)
    );

    assign prod_s = $signed(hl.rs) * $signed(hl.rt);
    assign prod_u = hl.rs * hl.rt;

    // divider result first, the stage holds one instruction at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_r <= '0;
            lo_r <= '0;
        end else if (div_done) begin
            hi_r <= remainder;
            lo_r <= quotient;
        end else if (hl.commit) begin
            case (hl.op)
                op_mult:  {hi_r, lo_r} <= prod_s;
                op_multu: {hi_r, lo_r} <= prod_u;
                op_mthi:  hi_r <= hl.rs;
                op_mtlo:  lo_r <= hl.rs;
                default:  ;
            endcase
        end
    end

    assign hl.busy = div_busy;
    assign hl.done = div_done;
    assign hl.hi   = hi_r;
    assign hl.lo   = lo_r;

endmodule

`default_nettype wire

//--- source/serial_divider.sv
`timescale 1ns/1ns
`default_nettype none

module serial_divider
    import exe_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  is_signed,
    input  word_t dividend,
    input  word_t divisor,
    output word_t quotient,
    output word_t remainder,
    output logic  busy,
    output logic  done
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_t;

    div_state_t          state;
    logic [5:0]          count;
    word_t               quo;
    word_t               rem;
    word_t               div_mag;
    logic                neg_q;
    logic                neg_r;
    logic [data_width:0] shifted;
    logic [data_width:0] trial;

    assign shifted = {rem, quo[data_width-1]};
    assign trial   = shifted - {1'b0, div_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    count <= count + 6'd1;
                    if (count == 6'(div_steps - 1)) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // magnitudes in, one quotient bit per step
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            quo     <= (is_signed && dividend[data_width-1]) ? -dividend : dividend;
            div_mag <= (is_signed && divisor[data_width-1]) ? -divisor : divisor;
            rem     <= '0;
            neg_q   <= is_signed && (dividend[data_width-1] ^ divisor[data_width-1]);
            neg_r   <= is_signed && dividend[data_width-1];
        end else if (state == st_run) begin
            if (!trial[data_width]) begin
                rem <= trial[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b1};
            end else begin
                rem <= shifted[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b0};
            end
        end
    end

    // remainder follows the dividend sign
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;
    assign busy      = (state == st_run);
    assign done      = (state == st_done);

endmodule

`default_nettype wire

//--- source/exe_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exe_alu
    import exe_pkg::*;
(
    input  exe_op_t op,
    input  word_t   rs,
    input  word_t   rt,
    input  imm_t    imm,
    output word_t   result,
    output logic    overflow
);

    word_t      src2;
    word_t      sext_imm;
    word_t      zext_imm;
    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;

    assign sext_imm = {{(data_width-16){imm[15]}}, imm};
    assign zext_imm = {{(data_width-16){1'b0}}, imm};
    assign shamt    = imm[shamt_msb:shamt_lsb];

    always_comb begin
        if (imm_is_zero_ext(op)) begin
            src2 = zext_imm;
        end else if (is_mem_op(op) || op inside {op_addi, op_addiu, op_slti, op_sltiu}) begin
            src2 = sext_imm;
        end else begin
            src2 = rt;
        end
    end

    assign sum  = rs + src2;
    assign diff = rs - src2;

    always_comb begin
        case (op)
            op_sub, op_subu:   result = diff;
            op_and, op_andi:   result = rs & src2;
            op_or, op_ori:     result = rs | src2;
            op_xor, op_xori:   result = rs ^ src2;
            op_nor:            result = ~(rs | src2);
            op_slt, op_slti:   result = word_t'($signed(rs) < $signed(src2));
            op_sltu, op_sltiu: result = word_t'(rs < src2);
            op_sll:            result = rt << shamt;
            op_srl:            result = rt >> shamt;
            op_sra:            result = $signed(rt) >>> shamt;
            op_lui:            result = {imm, 16'h0000};
            // adds and memory address
            default:           result = sum;
        endcase
    end

    // same-sign operands with a result of the other sign
    always_comb begin
        overflow = 1'b0;
        if (op == op_add || op == op_addi) begin
            overflow = (rs[data_width-1] == src2[data_width-1]) &&
                       (sum[data_width-1] != rs[data_width-1]);
        end else if (op == op_sub) begin
            overflow = (rs[data_width-1] != src2[data_width-1]) &&
                       (diff[data_width-1] != rs[data_width-1]);
        end
    end

endmodule

`default_nettype wire

//--- source/hilo_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hilo_if
    import exe_pkg::*;
();

    exe_op_t op;
    word_t   rs;
    word_t   rt;
    logic    start;
    logic    commit;
    logic    busy;
    logic    done;
    word_t   hi;
    word_t   lo;

    modport ctrl (
        output op, rs, rt, start, commit,
        input  busy, done, hi, lo
    );

    modport unit (
        input  op, rs, rt, start, commit,
        output busy, done, hi, lo
    );

endinterface

`default_nettype wire

//--- source/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int data_width = 32;
    localparam int div_steps  = 32;
    localparam int shamt_lsb  = 6;
    localparam int shamt_msb  = 10;

    typedef logic [data_width-1:0] word_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [15:0]           imm_t;
    typedef logic [3:0]            strobe_t;

    typedef enum logic [5:0] {
        op_add, op_addu, op_sub, op_subu, op_and, op_or, op_xor, op_nor,
        op_slt, op_sltu, op_sll, op_srl, op_sra,
        op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lui,
        op_mult, op_multu, op_div, op_divu, op_mfhi, op_mflo, op_mthi, op_mtlo,
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw
    } exe_op_t;

    // MIPS cause codes
    typedef enum logic [4:0] {
        exc_none     = 5'h00,
        exc_adel     = 5'h04,
        exc_ades     = 5'h05,
        exc_overflow = 5'h0c
    } exc_code_t;

    typedef enum logic [1:0] {
        acc_byte,
        acc_half,
        acc_word
    } acc_size_t;

    function automatic logic is_mem_op(exe_op_t op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};
    endfunction

    function automatic logic is_store(exe_op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    // instructions that write HI or LO
    function automatic logic is_hilo_op(exe_op_t op);
        return op inside {op_mult, op_multu, op_div, op_divu, op_mthi, op_mtlo};
    endfunction

    function automatic logic imm_is_zero_ext(exe_op_t op);
        return op inside {op_andi, op_ori, op_xori};
    endfunction

    function automatic acc_size_t access_size(exe_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return acc_byte;
            op_lh, op_lhu, op_sh: return acc_half;
            default:              return acc_word;
        endcase
    endfunction

endpackage

`default_nettype wire
